// ==== hw/dma_cfg.svh ====
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Register map on gp, byte addresses
`define DMA_REG_CTRL   16'h0000
`define DMA_REG_STATUS 16'h0004
`define DMA_REG_SRC    16'h0008
`define DMA_REG_DST    16'h000C
`define DMA_REG_LEN    16'h0010
`define DMA_REG_OFFSET 16'h0014

// The window maps the whole shared memory, one word per 4 bytes
`define DMA_WIN_BASE   16'h1000

// Word count of the shared memory
`define DMA_MEM_DEPTH  256

`endif

// ==== hw/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

    // ==============================
    // Bus payload types
    // ==============================

    typedef logic [31:0] word_t; // One data word on gp, hp and the memory

    typedef logic [15:0] addr_t; // Byte address on both AXI4-Lite ports

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_t;

    // ==============================
    // Copy engine FSM
    // ==============================

    typedef enum logic [2:0] {
        idle,
        rd_addr,
        rd_data,
        wr,
        wr_resp
    } copy_state_t;

endpackage

`default_nettype wire

// ==== hw/gp_reg_slave.sv ====
`default_nettype none

`include "dma_cfg.svh"

module gp_reg_slave (
    input  wire                  peripheral_clock,
    input  wire                  arst_n,
    input  wire dma_pkg::addr_t  gp_awaddr,
    input  wire                  gp_awvalid,
    output logic                 gp_awready,
    input  wire dma_pkg::word_t  gp_wdata,
    input  wire [3:0]            gp_wstrb,
    input  wire                  gp_wvalid,
    output logic                 gp_wready,
    output dma_pkg::resp_t       gp_bresp,
    output logic                 gp_bvalid,
    input  wire                  gp_bready,
    input  wire dma_pkg::addr_t  gp_araddr,
    input  wire                  gp_arvalid,
    output logic                 gp_arready,
    output dma_pkg::word_t       gp_rdata,
    output dma_pkg::resp_t       gp_rresp,
    output logic                 gp_rvalid,
    input  wire                  gp_rready,
    input  wire                  busy,
    output logic                 start,
    output dma_pkg::addr_t       src,
    output dma_pkg::addr_t       dst,
    output dma_pkg::word_t       len,
    output dma_pkg::addr_t       offset,
    output logic                 win_en,
    output logic                 win_we,
    output logic [7:0]           win_index,
    output dma_pkg::word_t       win_wdata,
    output logic [3:0]           win_wstrb,
    input  wire dma_pkg::word_t  win_rdata
);

    function automatic logic in_window(input dma_pkg::addr_t addr);
        return (addr >= `DMA_WIN_BASE) && (addr < `DMA_WIN_BASE + 4 * `DMA_MEM_DEPTH);
    endfunction

    logic           pend; // A response is outstanding
    logic           wr_fire;
    logic           rd_fire;
    logic           wr_is_reg;
    logic           wr_is_win;
    logic           rd_is_reg;
    logic           rd_is_win;
    logic           rd_win_q; // Window read waits one cycle for memory data
    dma_pkg::word_t rd_reg_data;

    // ==============================
    // Handshake and decode
    // ==============================

    assign gp_awready = !pend;
    assign gp_wready  = !pend;
    assign gp_arready = !pend && !(gp_awvalid && gp_wvalid); // Writes win a tie

    assign wr_fire = gp_awvalid && gp_wvalid && !pend;
    assign rd_fire = gp_arvalid && gp_arready;

    assign wr_is_win = in_window(gp_awaddr);
    assign rd_is_win = in_window(gp_araddr);
    assign wr_is_reg = gp_awaddr inside {`DMA_REG_CTRL, `DMA_REG_STATUS, `DMA_REG_SRC,
                                         `DMA_REG_DST, `DMA_REG_LEN, `DMA_REG_OFFSET};

    always_comb begin
        rd_is_reg   = 1'b1;
        rd_reg_data = '0;
        case (gp_araddr)
            `DMA_REG_CTRL:   rd_reg_data = '0;
            `DMA_REG_STATUS: rd_reg_data = {31'd0, busy};
            `DMA_REG_SRC:    rd_reg_data = {16'd0, src};
            `DMA_REG_DST:    rd_reg_data = {16'd0, dst};
            `DMA_REG_LEN:    rd_reg_data = len;
            `DMA_REG_OFFSET: rd_reg_data = {16'd0, offset};
            default:         rd_is_reg = 1'b0;
        endcase
    end

    assign win_we    = wr_fire && wr_is_win;
    assign win_en    = win_we || (rd_fire && rd_is_win);
    assign win_index = wr_fire ? gp_awaddr[9:2] : gp_araddr[9:2];
    assign win_wdata = gp_wdata;
    assign win_wstrb = gp_wstrb;

    // ==============================
    // Registers
    // ==============================

    always_ff @(posedge peripheral_clock or negedge arst_n) begin
        if (!arst_n) begin
            start  <= 1'b0;
            src    <= '0;
            dst    <= '0;
            len    <= '0;
            offset <= '0;
        end else begin
            start <= 1'b0;
            if (wr_fire) begin
                case (gp_awaddr)
                    `DMA_REG_CTRL:   start  <= gp_wdata[0]; // Pulse only, ctrl holds nothing
                    `DMA_REG_SRC:    src    <= gp_wdata[15:0];
                    `DMA_REG_DST:    dst    <= gp_wdata[15:0];
                    `DMA_REG_LEN:    len    <= gp_wdata;
                    `DMA_REG_OFFSET: offset <= gp_wdata[15:0];
                    default:         ;
                endcase
            end
        end
    end

    always_ff @(posedge peripheral_clock or negedge arst_n) begin
        if (!arst_n) begin
            pend      <= 1'b0;
            gp_bvalid <= 1'b0;
            gp_bresp  <= dma_pkg::resp_okay;
            gp_rvalid <= 1'b0;
            gp_rresp  <= dma_pkg::resp_okay;
            rd_win_q  <= 1'b0;
        end else begin
            if (wr_fire) begin
                pend      <= 1'b1;
                gp_bvalid <= 1'b1;
                gp_bresp  <= (wr_is_reg || wr_is_win) ? dma_pkg::resp_okay : dma_pkg::resp_slverr;
            end else if (rd_fire) begin
                pend <= 1'b1;
                if (rd_is_win) begin
                    rd_win_q <= 1'b1;
                end else begin
                    gp_rvalid <= 1'b1;
                    gp_rresp  <= rd_is_reg ? dma_pkg::resp_okay : dma_pkg::resp_slverr;
                end
            end
            if (rd_win_q) begin
                rd_win_q  <= 1'b0;
                gp_rvalid <= 1'b1;
                gp_rresp  <= dma_pkg::resp_okay;
            end
            if (gp_bvalid && gp_bready) begin
                gp_bvalid <= 1'b0;
                pend      <= 1'b0;
            end
            if (gp_rvalid && gp_rready) begin
                gp_rvalid <= 1'b0;
                pend      <= 1'b0;
            end
        end
    end

    always_ff @(posedge peripheral_clock) begin
        if (rd_fire) begin
            gp_rdata <= rd_reg_data; // Zero for unmapped addresses
        end else if (rd_win_q) begin
            gp_rdata <= win_rdata;
        end
    end

    bvalid_needs_write: assert property (@(posedge peripheral_clock) disable iff (!arst_n)
        $rose(gp_bvalid) |-> $past(wr_fire));

    rvalid_needs_read: assert property (@(posedge peripheral_clock) disable iff (!arst_n)
        $rose(gp_rvalid) |-> $past(rd_fire) || $past(rd_fire, 2));

endmodule

`default_nettype wire

// ==== hw/copy_engine.sv ====
`default_nettype none

module copy_engine (
    input  wire                  peripheral_clock,
    input  wire                  arst_n,
    input  wire                  start,
    input  wire dma_pkg::addr_t  src,
    input  wire dma_pkg::addr_t  dst,
    input  wire dma_pkg::word_t  len,
    output logic                 busy,
    output logic                 done,
    output dma_pkg::addr_t       hp_awaddr,
    output logic                 hp_awvalid,
    input  wire                  hp_awready,
    output dma_pkg::word_t       hp_wdata,
    output logic [3:0]           hp_wstrb,
    output logic                 hp_wvalid,
    input  wire                  hp_wready,
    input  wire dma_pkg::resp_t  hp_bresp,
    input  wire                  hp_bvalid,
    output logic                 hp_bready,
    output dma_pkg::addr_t       hp_araddr,
    output logic                 hp_arvalid,
    input  wire                  hp_arready,
    input  wire dma_pkg::word_t  hp_rdata,
    input  wire dma_pkg::resp_t  hp_rresp,
    input  wire                  hp_rvalid,
    output logic                 hp_rready
);

    dma_pkg::copy_state_t state;
    dma_pkg::word_t       idx; // Index of the word being copied
    dma_pkg::addr_t       src_q;
    dma_pkg::addr_t       dst_q;
    dma_pkg::word_t       len_q;
    dma_pkg::word_t       data_q;
    dma_pkg::addr_t       byte_off;

    assign byte_off   = {idx[13:0], 2'b00};
    assign hp_araddr  = src_q + byte_off;
    assign hp_awaddr  = dst_q + byte_off;
    assign hp_wdata   = data_q;
    assign hp_wstrb   = 4'b1111;
    assign hp_arvalid = (state == dma_pkg::rd_addr);
    assign hp_awvalid = (state == dma_pkg::wr);
    assign hp_wvalid  = (state == dma_pkg::wr);
    assign hp_rready  = 1'b1;
    assign hp_bready  = 1'b1;
    assign busy       = (state != dma_pkg::idle);

    // ==============================
    // Sequencer
    // ==============================

    always_ff @(posedge peripheral_clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= dma_pkg::idle;
            idx   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                dma_pkg::idle: begin
                    if (start) begin
                        if (len == '0) begin
                            done <= 1'b1; // Empty copy finishes at once
                        end else begin
                            idx   <= '0;
                            state <= dma_pkg::rd_addr;
                        end
                    end
                end
                dma_pkg::rd_addr: if (hp_arready) state <= dma_pkg::rd_data;
                dma_pkg::rd_data: if (hp_rvalid) state <= dma_pkg::wr;
                dma_pkg::wr:      if (hp_awready && hp_wready) state <= dma_pkg::wr_resp;
                dma_pkg::wr_resp: begin
                    if (hp_bvalid) begin
                        if (idx == len_q - 1) begin
                            state <= dma_pkg::idle;
                            done  <= 1'b1;
                        end else begin
                            idx   <= idx + 1;
                            state <= dma_pkg::rd_addr;
                        end
                    end
                end
                default: state <= dma_pkg::idle;
            endcase
        end
    end

    // Copy parameters are frozen at start so the host may reprogram during a copy
    always_ff @(posedge peripheral_clock) begin
        if (state == dma_pkg::idle && start) begin
            src_q <= src;
            dst_q <= dst;
            len_q <= len;
        end
        if (state == dma_pkg::rd_data && hp_rvalid) begin
            data_q <= hp_rdata;
        end
    end

    aw_with_w: assert property (@(posedge peripheral_clock) disable iff (!arst_n)
        hp_awvalid |-> hp_wvalid && (hp_awready == hp_wready));

    no_empty_copy: assert property (@(posedge peripheral_clock) disable iff (!arst_n)
        state == dma_pkg::rd_addr |-> len_q != '0);

    hp_resp_okay: assert property (@(posedge peripheral_clock) disable iff (!arst_n)
        (!hp_bvalid || hp_bresp == dma_pkg::resp_okay) &&
        (!hp_rvalid || hp_rresp == dma_pkg::resp_okay));

endmodule

`default_nettype wire

// ==== hw/hp_mem_port.sv ====
`default_nettype none

`include "dma_cfg.svh"

module hp_mem_port (
    input  wire                  peripheral_clock,
    input  wire                  arst_n,
    input  wire dma_pkg::addr_t  offset,
    input  wire dma_pkg::addr_t  hp_awaddr,
    input  wire                  hp_awvalid,
    output logic                 hp_awready,
    input  wire dma_pkg::word_t  hp_wdata,
    input  wire [3:0]            hp_wstrb,
    input  wire                  hp_wvalid,
    output logic                 hp_wready,
    output dma_pkg::resp_t       hp_bresp,
    output logic                 hp_bvalid,
    input  wire                  hp_bready,
    input  wire dma_pkg::addr_t  hp_araddr,
    input  wire                  hp_arvalid,
    output logic                 hp_arready,
    output dma_pkg::word_t       hp_rdata,
    output dma_pkg::resp_t       hp_rresp,
    output logic                 hp_rvalid,
    input  wire                  hp_rready,
    input  wire                  win_en,
    input  wire                  win_we,
    input  wire [7:0]            win_index,
    input  wire dma_pkg::word_t  win_wdata,
    input  wire [3:0]            win_wstrb,
    output dma_pkg::word_t       win_rdata
);

    localparam int index_w = $clog2(`DMA_MEM_DEPTH);

    dma_pkg::word_t     mem [`DMA_MEM_DEPTH];
    dma_pkg::addr_t     phys_raddr;
    dma_pkg::addr_t     phys_waddr;
    logic [index_w-1:0] rd_index;
    logic [index_w-1:0] wr_index;
    logic               rd_fire;
    logic               wr_fire;

    // Offset is added in byte space and wraps at 16 bits, then the index wraps at the depth
    assign phys_raddr = hp_araddr + offset;
    assign phys_waddr = hp_awaddr + offset;
    assign rd_index   = phys_raddr[index_w+1:2];
    assign wr_index   = phys_waddr[index_w+1:2];

    assign hp_arready = !hp_rvalid;
    assign hp_awready = !hp_bvalid;
    assign hp_wready  = !hp_bvalid;
    assign hp_bresp   = dma_pkg::resp_okay;
    assign hp_rresp   = dma_pkg::resp_okay;

    assign rd_fire = hp_arvalid && hp_arready;
    assign wr_fire = hp_awvalid && hp_wvalid && !hp_bvalid;

    always_ff @(posedge peripheral_clock or negedge arst_n) begin
        if (!arst_n) begin
            hp_bvalid <= 1'b0;
            hp_rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                hp_bvalid <= 1'b1;
            end else if (hp_bready) begin
                hp_bvalid <= 1'b0;
            end
            if (rd_fire) begin
                hp_rvalid <= 1'b1;
            end else if (hp_rready) begin
                hp_rvalid <= 1'b0;
            end
        end
    end

    // ==============================
    // Dual-port memory
    // ==============================

    always_ff @(posedge peripheral_clock) begin
        if (win_en) begin
            if (win_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (win_wstrb[b]) mem[win_index][8*b +: 8] <= win_wdata[8*b +: 8];
                end
            end
            win_rdata <= mem[win_index];
        end
        if (wr_fire) begin
            for (int b = 0; b < 4; b++) begin
                if (hp_wstrb[b]) mem[wr_index][8*b +: 8] <= hp_wdata[8*b +: 8]; // Port B last
            end
        end
        if (rd_fire) begin
            hp_rdata <= mem[rd_index];
        end
    end

    one_read_outstanding: assert property (@(posedge peripheral_clock) disable iff (!arst_n)
        rd_fire |=> !rd_fire until_with (hp_rvalid && hp_rready));

endmodule

`default_nettype wire

// ==== hw/dma_subsystem.sv ====
`default_nettype none

module dma_subsystem (
    input  wire                  peripheral_clock,
    input  wire                  arst_n,
    input  wire dma_pkg::addr_t  gp_awaddr,
    input  wire                  gp_awvalid,
    output logic                 gp_awready,
    input  wire dma_pkg::word_t  gp_wdata,
    input  wire [3:0]            gp_wstrb,
    input  wire                  gp_wvalid,
    output logic                 gp_wready,
    output dma_pkg::resp_t       gp_bresp,
    output logic                 gp_bvalid,
    input  wire                  gp_bready,
    input  wire dma_pkg::addr_t  gp_araddr,
    input  wire                  gp_arvalid,
    output logic                 gp_arready,
    output dma_pkg::word_t       gp_rdata,
    output dma_pkg::resp_t       gp_rresp,
    output logic                 gp_rvalid,
    input  wire                  gp_rready,
    output logic                 done
);

    // Copy control between the register block and the engine
    logic           start;
    logic           busy;
    dma_pkg::addr_t src;
    dma_pkg::addr_t dst;
    dma_pkg::word_t len;
    dma_pkg::addr_t offset;

    // Memory window, port A
    logic           win_en;
    logic           win_we;
    logic [7:0]     win_index;
    dma_pkg::word_t win_wdata;
    logic [3:0]     win_wstrb;
    dma_pkg::word_t win_rdata;

    // hp AXI4-Lite between the engine and the memory, port B
    dma_pkg::addr_t hp_awaddr;
    logic           hp_awvalid;
    logic           hp_awready;
    dma_pkg::word_t hp_wdata;
    logic [3:0]     hp_wstrb;
    logic           hp_wvalid;
    logic           hp_wready;
    dma_pkg::resp_t hp_bresp;
    logic           hp_bvalid;
    logic           hp_bready;
    dma_pkg::addr_t hp_araddr;
    logic           hp_arvalid;
    logic           hp_arready;
    dma_pkg::word_t hp_rdata;
    dma_pkg::resp_t hp_rresp;
    logic           hp_rvalid;
    logic           hp_rready;

    gp_reg_slave gp_reg_slave_inst (.*);

    copy_engine copy_engine_inst (.*);

    hp_mem_port hp_mem_port_inst (.*);

endmodule

`default_nettype wire

// ==== dv/dma_subsystem_tb.sv ====
`default_nettype none

`include "dma_cfg.svh"

module dma_subsystem_tb;

    localparam int timeout_cycles = 1000;

    logic           peripheral_clock;
    logic           arst_n;
    dma_pkg::addr_t gp_awaddr;
    logic           gp_awvalid;
    logic           gp_awready;
    dma_pkg::word_t gp_wdata;
    logic [3:0]     gp_wstrb;
    logic           gp_wvalid;
    logic           gp_wready;
    dma_pkg::resp_t gp_bresp;
    logic           gp_bvalid;
    logic           gp_bready;
    dma_pkg::addr_t gp_araddr;
    logic           gp_arvalid;
    logic           gp_arready;
    dma_pkg::word_t gp_rdata;
    dma_pkg::resp_t gp_rresp;
    logic           gp_rvalid;
    logic           gp_rready;
    logic           done;

    int   errors;
    logic timed_out; // Set by any expired wait, ends the stimulus loop

    dma_subsystem dma_subsystem_inst (.*);

    initial begin
        peripheral_clock = 1'b0;
        forever #4 peripheral_clock = ~peripheral_clock;
    end

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_word(input string name, input dma_pkg::word_t expected,
                              input dma_pkg::word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_resp(input string name, input dma_pkg::resp_t expected,
                              input dma_pkg::resp_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("Timeout: the %s did not happen within %0d cycles", what, timeout_cycles);
    endtask

    // ==============================
    // gp master
    // ==============================

    // Outputs are read right after the edge, so they are the values the DUT saw
    task automatic gp_write(input dma_pkg::addr_t addr, input dma_pkg::word_t data,
                            input logic [3:0] strb, output dma_pkg::resp_t resp);
        int   cycles;
        logic accepted;
        resp = dma_pkg::resp_okay;
        @(posedge peripheral_clock);
        gp_awaddr  <= addr;
        gp_awvalid <= 1'b1;
        gp_wdata   <= data;
        gp_wstrb   <= strb;
        gp_wvalid  <= 1'b1;
        gp_bready  <= 1'b1;
        accepted = 1'b0;
        cycles = 0;
        while (!accepted && cycles < timeout_cycles) begin
            @(posedge peripheral_clock);
            accepted = gp_awready && gp_wready;
            cycles++;
        end
        gp_awvalid <= 1'b0;
        gp_wvalid  <= 1'b0;
        if (!accepted) begin
            gp_bready <= 1'b0;
            report_timeout("gp write address and data handshake");
            return;
        end
        accepted = 1'b0;
        cycles = 0;
        while (!accepted && cycles < timeout_cycles) begin
            @(posedge peripheral_clock);
            accepted = gp_bvalid;
            cycles++;
        end
        gp_bready <= 1'b0;
        if (accepted) begin
            resp = gp_bresp;
        end else begin
            report_timeout("gp write response");
        end
    endtask

    task automatic gp_read(input dma_pkg::addr_t addr, output dma_pkg::word_t data,
                           output dma_pkg::resp_t resp);
        int   cycles;
        logic accepted;
        data = '0;
        resp = dma_pkg::resp_okay;
        @(posedge peripheral_clock);
        gp_araddr  <= addr;
        gp_arvalid <= 1'b1;
        gp_rready  <= 1'b1;
        accepted = 1'b0;
        cycles = 0;
        while (!accepted && cycles < timeout_cycles) begin
            @(posedge peripheral_clock);
            accepted = gp_arready;
            cycles++;
        end
        gp_arvalid <= 1'b0;
        if (!accepted) begin
            gp_rready <= 1'b0;
            report_timeout("gp read address handshake");
            return;
        end
        accepted = 1'b0;
        cycles = 0;
        while (!accepted && cycles < timeout_cycles) begin
            @(posedge peripheral_clock);
            accepted = gp_rvalid;
            cycles++;
        end
        gp_rready <= 1'b0;
        if (accepted) begin
            data = gp_rdata;
            resp = gp_rresp;
        end else begin
            report_timeout("gp read data");
        end
    endtask

    // An empty copy ends on the first cycle, a real copy needs at least 4 cycles a word
    task automatic wait_done(input dma_pkg::word_t copy_len);
        int   cycles;
        logic seen;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < timeout_cycles) begin
            @(posedge peripheral_clock);
            seen = done;
            cycles++;
        end
        if (!seen) begin
            report_timeout("copy done pulse");
        end else if (copy_len == '0 && cycles != 1) begin
            errors++;
            $display("The done pulse of an empty copy came %0d cycles after start, not 1",
                     cycles);
        end else if (copy_len != '0 && cycles < 4 * copy_len) begin
            errors++;
            $display("The done pulse came %0d cycles after start, too early for %0d words",
                     cycles, copy_len);
        end
    endtask

    // ==============================
    // Stimulus
    // ==============================

    initial begin
        int             fd;
        int             fields;
        string          line;
        byte            op;
        dma_pkg::addr_t addr;
        dma_pkg::word_t data;
        logic [3:0]     strb;
        logic [1:0]     resp_code;
        dma_pkg::resp_t resp;
        dma_pkg::word_t rdata;
        dma_pkg::word_t copy_len; // Last value written to the len register
        errors     = 0;
        timed_out  = 1'b0;
        copy_len   = '0;
        arst_n     = 1'b0;
        gp_awaddr  = '0;
        gp_awvalid = 1'b0;
        gp_wdata   = '0;
        gp_wstrb   = '0;
        gp_wvalid  = 1'b0;
        gp_bready  = 1'b0;
        gp_araddr  = '0;
        gp_arvalid = 1'b0;
        gp_rready  = 1'b0;
        repeat (8) @(posedge peripheral_clock);
        arst_n <= 1'b1;

        fd = $fopen("dv/dma_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("The stimulus file dv/dma_input.txt could not be opened");
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%c %h %h %h %h", op, addr, data, strb, resp_code);
                if (fields == 5 && op != "#") begin
                    case (op)
                        "w": begin
                            gp_write(addr, data, strb, resp);
                            if (!timed_out) begin
                                check_resp($sformatf("gp_bresp at %h", addr),
                                           dma_pkg::resp_t'(resp_code), resp);
                            end
                            if (addr == `DMA_REG_LEN) begin
                                copy_len = data;
                            end
                        end
                        "r": begin
                            gp_read(addr, rdata, resp);
                            if (!timed_out) begin
                                check_word($sformatf("gp_rdata at %h", addr), data, rdata);
                                check_resp($sformatf("gp_rresp at %h", addr),
                                           dma_pkg::resp_t'(resp_code), resp);
                            end
                        end
                        "s": begin
                            gp_write(`DMA_REG_CTRL, 32'h1, 4'hf, resp); // Start bit in ctrl
                            if (!timed_out) begin
                                check_resp("gp_bresp at ctrl", dma_pkg::resp_okay, resp);
                                wait_done(copy_len);
                            end
                            if (!timed_out) begin
                                gp_read(`DMA_REG_CTRL, rdata, resp); // Ctrl keeps no start bit
                            end
                            if (!timed_out) begin
                                check_word("gp_rdata at ctrl", '0, rdata);
                            end
                        end
                        default: begin
                            errors++;
                            $display("The stimulus file has an unknown operation %c", op);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/dma_input.txt ====
# op addr data strb resp, all hex; r takes data as the expected read data
# w writes data with strb and expects resp, r expects data and resp, s starts a copy and waits
w 0008 00000020 f 0
w 000c 00000040 f 0
w 0010 00000002 f 0
w 0014 00000000 f 0
w 0000 00000000 f 0
r 0000 00000000 0 0
r 0008 00000020 0 0
r 000c 00000040 0 0
r 0010 00000002 0 0
r 0014 00000000 0 0
w 1020 a5a50001 f 0
w 1024 a5a50002 f 0
w 103c 11111111 f 0
w 1048 22222222 f 0
w 1024 0000cc00 2 0
r 1024 a5a5cc02 0 0
s 0000 00000000 0 0
r 1040 a5a50001 0 0
r 1044 a5a5cc02 0 0
r 103c 11111111 0 0
r 1048 22222222 0 0
r 0004 00000000 0 0
w 1000 0badcafe f 0
w 0014 000003e0 f 0
w 0010 00000001 f 0
s 0000 00000000 0 0
r 1020 0badcafe 0 0
w 0010 00000000 f 0
s 0000 00000000 0 0
r 1020 0badcafe 0 0
r 0004 00000000 0 0
w 0800 12345678 f 2
r 0800 00000000 0 2

// ==== build.f ====
+incdir+hw
hw/dma_pkg.sv
hw/gp_reg_slave.sv
hw/copy_engine.sv
hw/hp_mem_port.sv
hw/dma_subsystem.sv
dv/dma_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: dma_subsystem

sources:
  - include_dirs:
      - hw
    files:
      - hw/dma_pkg.sv
      - hw/gp_reg_slave.sv
      - hw/copy_engine.sv
      - hw/hp_mem_port.sv
      - hw/dma_subsystem.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/dma_subsystem_tb.sv
